// ==== source/aluPkg.sv ====
package aluPkg;

	localparam int axiAddrWidth = 4; // Byte address, four 32-bit registers
	localparam int axiDataWidth = 32;
	localparam int opCodeWidth  = 3;
	localparam int flagsLsb     = 16; // Flags sit at bits 19:16 of the result word

	typedef logic [axiAddrWidth-1:0] axiAddrT;
	typedef logic [axiDataWidth-1:0] axiDataT;
	typedef logic [opCodeWidth-1:0]  opCodeT;
	typedef logic [1:0]              axiRespT;

	// Operation codes, 5 to 7 undefined
	localparam opCodeT opAdd = 3'd0;
	localparam opCodeT opSub = 3'd1;
	localparam opCodeT opSll = 3'd2; // Logical left
	localparam opCodeT opSra = 3'd3; // Arithmetic right
	localparam opCodeT opRor = 3'd4; // Rotate right

	localparam axiRespT respOkay   = 2'b00;
	localparam axiRespT respSlvErr = 2'b10;

	// Register map
	localparam axiAddrT regA      = 4'h0;
	localparam axiAddrT regB      = 4'h4;
	localparam axiAddrT regCtrl   = 4'h8;
	localparam axiAddrT regResult = 4'hC; // Read only

	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic c; // Carry, no borrow on subtract
		logic v; // Signed overflow
	} flagsT;

	// Master side of the bus
	typedef struct packed {
		logic    awValid;
		axiAddrT awAddr;
		logic    wValid;
		axiDataT wData;
		logic    bReady;
		logic    arValid;
		axiAddrT arAddr;
		logic    rReady;
	} axiReqT;

	// Slave side of the bus
	typedef struct packed {
		logic    awReady;
		logic    wReady;
		logic    bValid;
		axiRespT bResp;
		logic    arReady;
		logic    rValid;
		axiDataT rData;
		axiRespT rResp;
	} axiRspT;

endpackage

// ==== source/barrelShifter.sv ====
`timescale 1ns/1ps

module barrelShifter import aluPkg::*; #(
	parameter int dataWidth = 16
) (
	input  logic [dataWidth-1:0]         shiftIn,
	input  logic [$clog2(dataWidth)-1:0] shiftVal, // Shift amount
	input  opCodeT                       mode, // opSll, opSra or opRor
	output logic [dataWidth-1:0]         shiftOut
);
	localparam int shiftWidth = $clog2(dataWidth);
	localparam int numStages  = (shiftWidth + 1) / 2; // One stage per radix-4 digit

	typedef logic [dataWidth-1:0] wordT;

	wordT stageVal [numStages+1]; // Entry 0 is the raw input
	logic modeOk;

	// One fixed step of the selected shift kind
	function automatic wordT stepShift(input wordT value, input int amt, input opCodeT op);
		int   rotAmt;
		wordT res;
		rotAmt = amt % dataWidth;
		case (op)
			opSll:   res = value << amt; // Zero fill
			opSra:   res = wordT'($signed(value) >>> amt); // Sign fill
			opRor:   res = (value >> rotAmt) | (value << (dataWidth - rotAmt)); // Wrap around
			default: res = '0;
		endcase
		return res;
	endfunction

	assign stageVal[0] = shiftIn;

	for (genvar s = 0; s < numStages; s++) begin : gStage
		localparam int stepBase = 4 ** s; // Weight of this digit
		logic [1:0] digit;
		wordT       stageOut;

		if (2 * s + 1 < shiftWidth) begin : gFull
			assign digit = shiftVal[2*s+1:2*s];
		end else begin : gHalf
			assign digit = {1'b0, shiftVal[2*s]}; // Odd shift width, top digit has one bit
		end

		always_comb begin
			case (digit)
				2'd0:    stageOut = stageVal[s]; // Pass through
				2'd1:    stageOut = stepShift(stageVal[s], stepBase, mode);
				2'd2:    stageOut = stepShift(stageVal[s], 2 * stepBase, mode);
				default: stageOut = stepShift(stageVal[s], 3 * stepBase, mode);
			endcase
		end

		assign stageVal[s+1] = stageOut;
	end

	assign modeOk   = (mode == opSll) || (mode == opSra) || (mode == opRor);
	assign shiftOut = modeOk ? stageVal[numStages] : '0; // Non-shift codes give zero

endmodule

// ==== source/addSubUnit.sv ====
`timescale 1ns/1ps

module addSubUnit #(
	parameter int dataWidth = 16
) (
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic                 sub, // 1 = a - b
	output logic [dataWidth-1:0] sum,
	output logic                 carry, // Carry out, no borrow when subtracting
	output logic                 overflow // Signed overflow
);
	logic [dataWidth-1:0] bEff; // b as the adder sees it
	logic                 signA;
	logic                 signB;
	logic                 signSum;

	assign bEff = sub ? ~b : b; // Two's complement via invert plus carry in

	assign {carry, sum} = {1'b0, a} + {1'b0, bEff} + {{dataWidth{1'b0}}, sub};

	assign signA   = a[dataWidth-1];
	assign signB   = bEff[dataWidth-1];
	assign signSum = sum[dataWidth-1];

	// Like signs in, different sign out
	assign overflow = (signA == signB) && (signSum != signA);

endmodule

// ==== source/resultCombine.sv ====
`timescale 1ns/1ps

module resultCombine import aluPkg::*; #(
	parameter int dataWidth = 16
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 launch, // One-cycle start pulse
	input  opCodeT               opCode,
	input  logic [dataWidth-1:0] shiftOut,
	input  logic [dataWidth-1:0] sum,
	input  logic                 carry,
	input  logic                 overflow,
	output logic [dataWidth-1:0] result,
	output flagsT                flags
);
	logic                 isArith; // Add or subtract selected
	logic [dataWidth-1:0] nextResult;
	flagsT                nextFlags;

	assign isArith    = (opCode == opAdd) || (opCode == opSub);
	assign nextResult = isArith ? sum : shiftOut;

	always_comb begin
		nextFlags.n = nextResult[dataWidth-1]; // Sign of result
		nextFlags.z = (nextResult == '0);
		nextFlags.c = isArith & carry; // Shifts clear c and v
		nextFlags.v = isArith & overflow;
	end

	// Hold outcome until the next launch
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			flags  <= '0;
		end else if (launch) begin
			result <= nextResult;
			flags  <= nextFlags;
		end
	end

endmodule

// ==== source/axiLiteRegs.sv ====
`timescale 1ns/1ps

module axiLiteRegs import aluPkg::*; #(
	parameter int dataWidth = 16
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  axiReqT               axiReq,
	output axiRspT               axiRsp,
	output logic [dataWidth-1:0] opA,
	output logic [dataWidth-1:0] opB,
	output opCodeT               opCode,
	output logic                 launch, // Pulse on valid control write
	input  logic [dataWidth-1:0] result,
	input  flagsT                flags
);
	typedef enum logic {wrIdle, wrResp} wrStateT;
	typedef enum logic {rdIdle, rdResp} rdStateT;

	wrStateT wrState;
	rdStateT rdState;

	logic    wrEn; // AW and W taken this cycle
	logic    rdEn; // AR taken this cycle
	logic    arReadyQ; // Registered so it stays low through reset
	opCodeT  newOp; // Code carried by the write data
	logic    ctrlOk; // Code is defined
	logic    wrOk; // Write goes to a writable register
	logic    rdMapped;
	axiRespT bRespQ;
	axiRespT rRespQ;
	axiAddrT rdAddrQ; // Address of the pending read
	axiDataT resultWord;
	axiDataT readWord;

	assign wrEn = (wrState == wrIdle) && axiReq.awValid && axiReq.wValid;
	assign rdEn = arReadyQ && axiReq.arValid;

	assign newOp  = axiReq.wData[opCodeWidth-1:0];
	assign ctrlOk = (newOp <= opRor); // 5 to 7 undefined

	always_comb begin
		case (axiReq.awAddr)
			regA, regB: wrOk = 1'b1;
			regCtrl:    wrOk = ctrlOk; // Bad code changes nothing
			default:    wrOk = 1'b0; // Unmapped or regResult
		endcase
	end

	assign rdMapped = axiReq.arAddr inside {regA, regB, regCtrl, regResult};

	// Write channel FSM and register file
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrState <= wrIdle;
			bRespQ  <= respOkay;
			opA     <= '0;
			opB     <= '0;
			opCode  <= opAdd;
			launch  <= 1'b0;
		end else begin
			launch <= 1'b0; // Default low, single cycle
			case (wrState)
				wrIdle: begin
					if (wrEn) begin
						wrState <= wrResp;
						bRespQ  <= wrOk ? respOkay : respSlvErr;
						if (wrOk) begin
							case (axiReq.awAddr)
								regA: opA <= axiReq.wData[dataWidth-1:0];
								regB: opB <= axiReq.wData[dataWidth-1:0];
								regCtrl: begin
									opCode <= newOp;
									launch <= 1'b1; // Start the operation
								end
								default: ;
							endcase
						end
					end
				end
				wrResp: begin
					if (axiReq.bReady) begin
						wrState <= wrIdle; // Response taken
					end
				end
				default: wrState <= wrIdle;
			endcase
		end
	end

	// Read channel FSM
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdState  <= rdIdle;
			arReadyQ <= 1'b0;
			rRespQ   <= respOkay;
			rdAddrQ  <= '0;
		end else begin
			case (rdState)
				rdIdle: begin
					arReadyQ <= 1'b1; // Open after reset
					if (rdEn) begin
						rdState  <= rdResp;
						arReadyQ <= 1'b0;
						rdAddrQ  <= axiReq.arAddr;
						rRespQ   <= rdMapped ? respOkay : respSlvErr;
					end
				end
				rdResp: begin
					if (axiReq.rReady) begin
						rdState  <= rdIdle;
						arReadyQ <= 1'b1; // Ready again at once
					end
				end
				default: rdState <= rdIdle;
			endcase
		end
	end

	// Result in the low bits, flags at 19:16
	always_comb begin
		resultWord = '0;
		resultWord[dataWidth-1:0] = result;
		resultWord[flagsLsb +: $bits(flagsT)] = flags;
	end

	// Readback mux on the held address
	always_comb begin
		case (rdAddrQ)
			regA:      readWord = axiDataT'(opA); // Zero-extended
			regB:      readWord = axiDataT'(opB);
			regCtrl:   readWord = axiDataT'(opCode);
			regResult: readWord = resultWord;
			default:   readWord = '0; // Unmapped reads return zero
		endcase
	end

	always_comb begin
		axiRsp.awReady = wrEn; // AW and W accepted together
		axiRsp.wReady  = wrEn;
		axiRsp.bValid  = (wrState == wrResp);
		axiRsp.bResp   = bRespQ;
		axiRsp.arReady = arReadyQ;
		axiRsp.rValid  = (rdState == rdResp);
		axiRsp.rData   = (rdState == rdResp) ? readWord : '0;
		axiRsp.rResp   = rRespQ;
	end

endmodule

// ==== source/shiftAluTop.sv ====
`timescale 1ns/1ps

module shiftAluTop import aluPkg::*; #(
	parameter int dataWidth = 16 // 8 or 16, flags use bits 19:16
) (
	input  logic   clk,
	input  logic   arstN,
	input  axiReqT axiReq,
	output axiRspT axiRsp
);
	localparam int shiftWidth = $clog2(dataWidth);

	logic [dataWidth-1:0]  opA;
	logic [dataWidth-1:0]  opB;
	opCodeT                opCode;
	logic                  launch;
	logic                  sub; // Adder in subtract mode
	logic [shiftWidth-1:0] shiftAmt; // Low bits of operand B
	logic [dataWidth-1:0]  shiftOut;
	logic [dataWidth-1:0]  sum;
	logic                  carry;
	logic                  overflow;
	logic [dataWidth-1:0]  result;
	flagsT                 flags;

	assign sub      = (opCode == opSub);
	assign shiftAmt = opB[shiftWidth-1:0];

	axiLiteRegs #(.dataWidth(dataWidth)) regs_i (
		.clk(clk), .arstN(arstN),
		.axiReq(axiReq), .axiRsp(axiRsp),
		.opA(opA), .opB(opB), .opCode(opCode), .launch(launch),
		.result(result), .flags(flags)
	);

	barrelShifter #(.dataWidth(dataWidth)) shifter_i (
		.shiftIn(opA), .shiftVal(shiftAmt), .mode(opCode), .shiftOut(shiftOut)
	);

	addSubUnit #(.dataWidth(dataWidth)) adder_i (
		.a(opA), .b(opB), .sub(sub),
		.sum(sum), .carry(carry), .overflow(overflow)
	);

	resultCombine #(.dataWidth(dataWidth)) combine_i (
		.clk(clk), .arstN(arstN),
		.launch(launch), .opCode(opCode),
		.shiftOut(shiftOut), .sum(sum), .carry(carry), .overflow(overflow),
		.result(result), .flags(flags)
	);

endmodule

// ==== bench/shiftAlu_asserts.sv ====
`timescale 1ns/1ps

module shiftAluAsserts import aluPkg::*; (
	input logic   clk,
	input logic   arstN,
	input axiReqT axiReq,
	input axiRspT axiRsp,
	input logic   launch
);
	logic ctrlTaken; // Valid control write accepted this cycle

	assign ctrlTaken = axiRsp.awReady && (axiReq.awAddr == regCtrl) &&
		(axiReq.wData[opCodeWidth-1:0] <= opRor);

	bHold: assert property (@(posedge clk) disable iff (!arstN)
		axiRsp.bValid && !axiReq.bReady |=> axiRsp.bValid && $stable(axiRsp.bResp))
		else $error("Write response dropped or changed before bReady");

	rHold: assert property (@(posedge clk) disable iff (!arstN)
		axiRsp.rValid && !axiReq.rReady |=> axiRsp.rValid && $stable(axiRsp.rData)
			&& $stable(axiRsp.rResp))
		else $error("Read response dropped or changed before rReady");

	launchPulse: assert property (@(posedge clk) disable iff (!arstN)
		launch |=> !launch)
		else $error("launch high for more than one cycle");

	launchCause: assert property (@(posedge clk) disable iff (!arstN)
		launch |-> $past(ctrlTaken))
		else $error("launch without an accepted control write");

	// All handshake outputs quiet in reset
	resetQuiet: assert property (@(posedge clk)
		!arstN |-> !(axiRsp.awReady || axiRsp.wReady || axiRsp.bValid || axiRsp.arReady
			|| axiRsp.rValid || launch))
		else $error("Ready, valid or launch high during reset");

endmodule

bind axiLiteRegs shiftAluAsserts asserts_i (
	.clk(clk), .arstN(arstN), .axiReq(axiReq), .axiRsp(axiRsp), .launch(launch)
);

// ==== bench/shiftAluTb.sv ====
`timescale 1ns/1ps

module shiftAluTb import aluPkg::*; ();

	localparam int dataWidth      = 16;
	localparam int numRandom      = 40;
	localparam int cyclesPerEntry = 60; // Budget per table or random entry
	localparam int resetCycles    = 8;

	typedef logic [dataWidth-1:0] wordT;

	// One row of the stimulus table
	typedef struct packed {
		opCodeT  op;
		wordT    a;
		wordT    b;
		wordT    res; // Expected result
		flagsT   flags; // Expected nzcv
		axiRespT resp; // Expected control write response
	} vecT;

	logic    clk = 1'b0;
	logic    arstN;
	axiReqT  axiReq;
	axiRspT  axiRsp;
	vecT     vecQ [$];
	int      errCount     = 0;
	int      cycleCount   = 0;
	int      timeoutLimit = 0; // Zero until the table is built
	axiDataT lastWord     = '0; // Result word held by the DUT

	shiftAluTop #(.dataWidth(dataWidth)) dut_i (
		.clk(clk), .arstN(arstN), .axiReq(axiReq), .axiRsp(axiRsp)
	);

	always #2 clk = ~clk; // 4 ns period

	// Run limit
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", timeoutLimit);
			$display("Done: errors found");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic checkEq(input string name, input axiDataT got, input axiDataT exp);
		if (got !== exp) begin
			errCount++;
			$display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
			$display("Done: errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Result in the low bits, flags at 19:16
	function automatic axiDataT packResult(input wordT res, input flagsT f);
		axiDataT word;
		word = '0;
		word[dataWidth-1:0] = res;
		word[flagsLsb +: 4] = f;
		return word;
	endfunction

	// Reference model, built bit by bit from the fill and flag rules
	function automatic axiDataT modelWord(input opCodeT op, input wordT a, input wordT b);
		logic [dataWidth:0] wide; // Sum with carry out
		wordT               res;
		flagsT              f;
		int                 amt;
		amt  = int'(b[$clog2(dataWidth)-1:0]);
		f    = '0;
		res  = a;
		wide = '0;
		case (op)
			opAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				res  = wide[dataWidth-1:0];
				f.c  = wide[dataWidth];
				f.v  = (a[dataWidth-1] == b[dataWidth-1]) && (res[dataWidth-1] != a[dataWidth-1]);
			end
			opSub: begin
				wide = {1'b0, a} + {1'b0, ~b} + {{dataWidth{1'b0}}, 1'b1};
				res  = wide[dataWidth-1:0];
				f.c  = wide[dataWidth]; // Set when no borrow
				f.v  = (a[dataWidth-1] != b[dataWidth-1]) && (res[dataWidth-1] != a[dataWidth-1]);
			end
			opSll:   repeat (amt) res = {res[dataWidth-2:0], 1'b0}; // Zero in at the bottom
			opSra:   repeat (amt) res = {res[dataWidth-1], res[dataWidth-1:1]}; // Sign copied down
			opRor:   repeat (amt) res = {res[0], res[dataWidth-1:1]}; // Bit 0 wraps to the top
			default: res = '0;
		endcase
		f.n = res[dataWidth-1];
		f.z = (res == '0);
		return packResult(res, f);
	endfunction

	task automatic axiWrite(input axiAddrT addr, input axiDataT data, input int stall,
			output axiRespT resp);
		axiRespT firstResp;
		@(posedge clk);
		#1;
		axiReq.awValid = 1'b1;
		axiReq.awAddr  = addr;
		axiReq.wValid  = 1'b1;
		axiReq.wData   = data;
		axiReq.bReady  = (stall == 0); // Low while back-pressure lasts
		do begin
			@(negedge clk);
		end while (!axiRsp.awReady);
		checkEq("wReady", axiDataT'(axiRsp.wReady), 32'd1); // W taken with AW
		@(posedge clk); // AW and W taken here
		#1;
		axiReq.awValid = 1'b0;
		axiReq.wValid  = 1'b0;
		@(negedge clk);
		checkEq("bValid", axiDataT'(axiRsp.bValid), 32'd1);
		firstResp = axiRsp.bResp;
		for (int i = 0; i < stall; i++) begin
			@(posedge clk);
			#1;
			if (i == stall - 1)
				axiReq.bReady = 1'b1;
			@(negedge clk);
			checkEq("bValid held", axiDataT'(axiRsp.bValid), 32'd1);
			checkEq("bResp held", axiDataT'(axiRsp.bResp), axiDataT'(firstResp));
		end
		@(posedge clk); // Response taken
		#1;
		axiReq.bReady = 1'b0;
		resp = firstResp;
	endtask

	task automatic axiRead(input axiAddrT addr, input int stall, output axiDataT data,
			output axiRespT resp);
		axiDataT firstData;
		axiRespT firstResp;
		@(posedge clk);
		#1;
		axiReq.arValid = 1'b1;
		axiReq.arAddr  = addr;
		axiReq.rReady  = (stall == 0);
		do begin
			@(negedge clk);
		end while (!axiRsp.arReady);
		@(posedge clk); // Address taken
		#1;
		axiReq.arValid = 1'b0;
		@(negedge clk);
		checkEq("rValid", axiDataT'(axiRsp.rValid), 32'd1);
		firstData = axiRsp.rData;
		firstResp = axiRsp.rResp;
		for (int i = 0; i < stall; i++) begin
			@(posedge clk);
			#1;
			if (i == stall - 1)
				axiReq.rReady = 1'b1;
			@(negedge clk);
			checkEq("rValid held", axiDataT'(axiRsp.rValid), 32'd1);
			checkEq("rData held", axiRsp.rData, firstData);
			checkEq("rResp held", axiDataT'(axiRsp.rResp), axiDataT'(firstResp));
		end
		@(posedge clk);
		#1;
		axiReq.rReady = 1'b0;
		data = firstData;
		resp = firstResp;
	endtask

	// Operands, control write, then result readback
	task automatic runOp(input opCodeT op, input wordT a, input wordT b, input axiDataT expWord,
			input axiRespT expResp, input int stall);
		axiRespT resp;
		axiDataT data;
		axiWrite(regA, axiDataT'(a), stall, resp);
		checkEq("bResp regA", axiDataT'(resp), axiDataT'(respOkay));
		axiWrite(regB, axiDataT'(b), stall, resp);
		checkEq("bResp regB", axiDataT'(resp), axiDataT'(respOkay));
		axiWrite(regCtrl, axiDataT'(op), stall, resp);
		checkEq("bResp regCtrl", axiDataT'(resp), axiDataT'(expResp));
		axiRead(regResult, stall, data, resp);
		checkEq("rResp regResult", axiDataT'(resp), axiDataT'(respOkay));
		checkEq("rData regResult", data, expWord);
		if (expResp == respOkay)
			lastWord = expWord;
	endtask

	function automatic void addVec(input opCodeT op, input wordT a, input wordT b,
			input wordT res, input flagsT flags, input axiRespT resp);
		vecT v;
		v.op    = op;
		v.a     = a;
		v.b     = b;
		v.res   = res;
		v.flags = flags;
		v.resp  = resp;
		vecQ.push_back(v);
	endfunction

	// Flags column is nzcv
	task automatic fillTable();
		addVec(opSll, 16'h1234, 16'h0000, 16'h1234, 4'b0000, respOkay);
		addVec(opSll, 16'h8001, 16'h0001, 16'h0002, 4'b0000, respOkay); // Top bit lost
		addVec(opSll, 16'h0101, 16'h0013, 16'h0808, 4'b0000, respOkay); // Only low 4 bits count
		addVec(opSll, 16'h1234, 16'h0004, 16'h2340, 4'b0000, respOkay);
		addVec(opSll, 16'h00FF, 16'h0007, 16'h7F80, 4'b0000, respOkay);
		addVec(opSll, 16'h000F, 16'h000C, 16'hF000, 4'b1000, respOkay);
		addVec(opSll, 16'h0001, 16'h000F, 16'h8000, 4'b1000, respOkay);
		addVec(opSll, 16'hFFFE, 16'h000F, 16'h0000, 4'b0100, respOkay);
		addVec(opSra, 16'h1234, 16'h0000, 16'h1234, 4'b0000, respOkay);
		addVec(opSra, 16'h4000, 16'h0001, 16'h2000, 4'b0000, respOkay);
		addVec(opSra, 16'h8000, 16'h0003, 16'hF000, 4'b1000, respOkay); // Sign fill
		addVec(opSra, 16'hF0F0, 16'h0004, 16'hFF0F, 4'b1000, respOkay);
		addVec(opSra, 16'h7F00, 16'h0007, 16'h00FE, 4'b0000, respOkay);
		addVec(opSra, 16'h9ABC, 16'h000C, 16'hFFF9, 4'b1000, respOkay);
		addVec(opSra, 16'h8000, 16'h000F, 16'hFFFF, 4'b1000, respOkay);
		addVec(opSra, 16'h7FFF, 16'h000F, 16'h0000, 4'b0100, respOkay);
		addVec(opRor, 16'h8001, 16'h0000, 16'h8001, 4'b1000, respOkay);
		addVec(opRor, 16'h0001, 16'h0001, 16'h8000, 4'b1000, respOkay); // Wraps to the top
		addVec(opRor, 16'h5555, 16'h0003, 16'hAAAA, 4'b1000, respOkay);
		addVec(opRor, 16'h1234, 16'h0004, 16'h4123, 4'b0000, respOkay);
		addVec(opRor, 16'h00F0, 16'h0007, 16'hE001, 4'b1000, respOkay);
		addVec(opRor, 16'hABCD, 16'h000C, 16'hBCDA, 4'b1000, respOkay);
		addVec(opRor, 16'h8001, 16'h000F, 16'h0003, 4'b0000, respOkay);
		addVec(opAdd, 16'h1234, 16'h4321, 16'h5555, 4'b0000, respOkay);
		addVec(opAdd, 16'h7FFF, 16'h0001, 16'h8000, 4'b1001, respOkay); // Signed overflow
		addVec(opAdd, 16'hFFFF, 16'h0001, 16'h0000, 4'b0110, respOkay); // Carry out, zero
		addVec(opAdd, 16'h8000, 16'h8000, 16'h0000, 4'b0111, respOkay);
		addVec(opSub, 16'h8000, 16'h0001, 16'h7FFF, 4'b0011, respOkay);
		addVec(opSub, 16'h1234, 16'h1234, 16'h0000, 4'b0110, respOkay); // Equal, no borrow
		addVec(opSub, 16'h0000, 16'h0001, 16'hFFFF, 4'b1000, respOkay); // Borrow clears c
		addVec(opSub, 16'h7FFF, 16'hFFFF, 16'h8000, 4'b1001, respOkay);
		// Undefined codes leave the previous outcome in place
		addVec(3'd5, 16'h0001, 16'h0001, 16'h8000, 4'b1001, respSlvErr);
		addVec(3'd6, 16'hFFFF, 16'h0002, 16'h8000, 4'b1001, respSlvErr);
		addVec(3'd7, 16'h0000, 16'h0000, 16'h8000, 4'b1001, respSlvErr);
	endtask

	task automatic checkRegAccess();
		axiRespT resp;
		axiDataT data;
		axiWrite(regA, 32'hFFFF_BEEF, 1, resp);
		checkEq("bResp regA", axiDataT'(resp), axiDataT'(respOkay));
		axiRead(regA, 2, data, resp);
		checkEq("rData regA", data, 32'h0000_BEEF); // Zero-extended
		checkEq("rResp regA", axiDataT'(resp), axiDataT'(respOkay));
		axiWrite(regB, 32'h1234_C0DE, 2, resp);
		checkEq("bResp regB", axiDataT'(resp), axiDataT'(respOkay));
		axiRead(regB, 1, data, resp);
		checkEq("rData regB", data, 32'h0000_C0DE);
		checkEq("rResp regB", axiDataT'(resp), axiDataT'(respOkay));
		axiWrite(regResult, 32'h0000_5A5A, 0, resp); // Read-only register
		checkEq("bResp regResult", axiDataT'(resp), axiDataT'(respSlvErr));
		axiWrite(4'h2, 32'h0000_0001, 0, resp);
		checkEq("bResp unmapped", axiDataT'(resp), axiDataT'(respSlvErr));
		axiRead(4'h6, 0, data, resp);
		checkEq("rResp unmapped", axiDataT'(resp), axiDataT'(respSlvErr));
		checkEq("rData unmapped", data, 32'h0000_0000);
		axiRead(regResult, 0, data, resp); // Outcome untouched by any of the above
		checkEq("rData regResult", data, lastWord);
		checkEq("rResp regResult", axiDataT'(resp), axiDataT'(respOkay));
	endtask

	initial begin
		vecT    v;
		opCodeT op;
		wordT   a;
		wordT   b;
		int     stall;
		void'($urandom(34150));
		arstN  = 1'b0;
		axiReq = '0;
		fillTable();
		timeoutLimit = cyclesPerEntry * (vecQ.size() + numRandom + 2) + resetCycles;
		repeat (resetCycles) @(posedge clk);
		#1;
		arstN = 1'b1;
		foreach (vecQ[i]) begin
			v = vecQ[i];
			runOp(v.op, v.a, v.b, packResult(v.res, v.flags), v.resp, 0);
		end
		checkRegAccess();
		// Random operations with random response back-pressure
		for (int i = 0; i < numRandom; i++) begin
			op    = opCodeT'($urandom % 5);
			a     = wordT'($urandom);
			b     = wordT'($urandom);
			stall = int'($urandom % 4);
			runOp(op, a, b, modelWord(op, a, b), respOkay, stall);
		end
		if (errCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
source/aluPkg.sv
source/barrelShifter.sv
source/addSubUnit.sv
source/resultCombine.sv
source/axiLiteRegs.sv
source/shiftAluTop.sv
bench/shiftAlu_asserts.sv
bench/shiftAluTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= shiftAluTb
RTL_TOP   ?= shiftAluTop
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint lint-rtl sim clean

all: sim

lint: lint-rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint-rtl:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
